// ==== adv_timer_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, register map and enums of the APB advanced timer
// Imported by the interface and all RTL blocks
// ~~~~~~~~~~~~~~~~~~~~
package adv_timer_pkg;

   // Widths
   localparam int CNT_W   = 16;  // Counter and threshold width
   localparam int PRESC_W = 8;
   localparam int ADDR_W  = 8;   // APB byte address
   localparam int DATA_W  = 32;
   localparam int N_CH    = 4;   // Compare channels

   // Register byte offsets
   localparam logic [ADDR_W-1:0] REG_CMD     = 8'h00;
   localparam logic [ADDR_W-1:0] REG_CFG     = 8'h04;
   localparam logic [ADDR_W-1:0] REG_TH      = 8'h08;
   localparam logic [ADDR_W-1:0] REG_CH0     = 8'h0C;
   localparam logic [ADDR_W-1:0] REG_CH1     = 8'h10;
   localparam logic [ADDR_W-1:0] REG_CH2     = 8'h14;
   localparam logic [ADDR_W-1:0] REG_CH3     = 8'h18;
   localparam logic [ADDR_W-1:0] REG_COUNTER = 8'h1C;
   localparam logic [ADDR_W-1:0] REG_STATUS  = 8'h20;

   // Bits of the REG_CMD word, one pulse each
   localparam int CMD_START_BIT  = 0;
   localparam int CMD_STOP_BIT   = 1;
   localparam int CMD_UPDATE_BIT = 2;
   localparam int CMD_RESET_BIT  = 3;

   // Action taken on a compare match
   typedef enum logic [2:0] {
      OP_SET     = 3'd0,  // High at match
      OP_CLEAR   = 3'd1,  // Low at match
      OP_TOGGLE  = 3'd2,  // Invert at match
      OP_SET_CLR = 3'd3   // High at match, low at period start
   } comp_op_e;

   // Counter run state
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_UP   = 2'd1,
      ST_DOWN = 2'd2
   } cnt_state_e;

endpackage

// ==== timer_cfg_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Active timer configuration and command pulses
// Driven by the register block, read by the counter and channels
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface timer_cfg_if;
   import adv_timer_pkg::*;

   logic               start_p;   // One-cycle commands
   logic               stop_p;
   logic               rst_p;
   logic [PRESC_W-1:0] presc;
   logic               sawtooth;
   logic [CNT_W-1:0]   cnt_start;
   logic [CNT_W-1:0]   cnt_end;
   logic [CNT_W-1:0]   comp [N_CH];
   comp_op_e           op   [N_CH];

   modport regs (output start_p, stop_p, rst_p, presc, sawtooth,
                 output cnt_start, cnt_end, comp, op);

   modport cnt (input start_p, stop_p, rst_p, presc, sawtooth, cnt_start, cnt_end);

   modport ch (input rst_p, comp, op);

endinterface

// ==== apb_timer_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// APB register block of the timer, zero wait states
// Stages configuration and applies it on the update command
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module apb_timer_regs (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [adv_timer_pkg::ADDR_W-1:0]   paddr_i,
   input  logic [adv_timer_pkg::DATA_W-1:0]   pwdata_i,
   input  logic [adv_timer_pkg::CNT_W-1:0]    counter_i,
   input  logic                               running_i,
   input  logic [adv_timer_pkg::N_CH-1:0]     pwm_i,
   output logic [adv_timer_pkg::DATA_W-1:0]   prdata_o,
   output logic                               pslverr_o,
   timer_cfg_if.regs                          cfg
);
   import adv_timer_pkg::*;

   logic                       access;
   logic                       wr_en;
   logic                       rd_en;
   logic                       cmd_wr;
   logic                       addr_hit;
   logic                       ch_hit;
   logic [$clog2(N_CH)-1:0]    ch_idx;
   logic                       update_p;
   logic [DATA_W-1:0]          rdata;

   // Staged configuration
   logic [PRESC_W-1:0]         presc_q;
   logic                       sawtooth_q;
   logic [CNT_W-1:0]           start_q;
   logic [CNT_W-1:0]           end_q;
   logic [CNT_W-1:0]           comp_q [N_CH];
   logic [2:0]                 op_q   [N_CH];  // Raw field, read back as written

   assign access = psel_i & penable_i;
   assign wr_en  = access & pwrite_i;
   assign rd_en  = access & ~pwrite_i;
   assign cmd_wr = wr_en && (paddr_i == REG_CMD);

   always_comb begin
      ch_hit = 1'b1;
      ch_idx = '0;
      case (paddr_i)
         REG_CH0: ch_idx = 2'd0;
         REG_CH1: ch_idx = 2'd1;
         REG_CH2: ch_idx = 2'd2;
         REG_CH3: ch_idx = 2'd3;
         default: ch_hit = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         presc_q    <= '0;
         sawtooth_q <= 1'b0;
         start_q    <= '0;
         end_q      <= '0;
         for (int i = 0; i < N_CH; i++) begin
            comp_q[i] <= '0;
            op_q[i]   <= '0;
         end
      end else if (wr_en) begin
         case (paddr_i)
            REG_CFG: begin
               presc_q    <= pwdata_i[PRESC_W-1:0];
               sawtooth_q <= pwdata_i[8];
            end
            REG_TH: begin
               start_q <= pwdata_i[15:0];
               end_q   <= pwdata_i[31:16];
            end
            default: ;
         endcase
         if (ch_hit) begin
            comp_q[ch_idx] <= pwdata_i[15:0];
            op_q[ch_idx]   <= pwdata_i[18:16];
         end
      end
   end

   // Command word to single-cycle pulses
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg.start_p <= 1'b0;
         cfg.stop_p  <= 1'b0;
         cfg.rst_p   <= 1'b0;
         update_p    <= 1'b0;
      end else begin
         cfg.start_p <= cmd_wr & pwdata_i[CMD_START_BIT];
         cfg.stop_p  <= cmd_wr & pwdata_i[CMD_STOP_BIT];
         cfg.rst_p   <= cmd_wr & pwdata_i[CMD_RESET_BIT];
         update_p    <= cmd_wr & pwdata_i[CMD_UPDATE_BIT];
      end
   end

   // Active copy, loaded the cycle after the update pulse
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg.presc     <= '0;
         cfg.sawtooth  <= 1'b0;
         cfg.cnt_start <= '0;
         cfg.cnt_end   <= '0;
         for (int i = 0; i < N_CH; i++) begin
            cfg.comp[i] <= '0;
            cfg.op[i]   <= OP_SET;
         end
      end else if (update_p) begin
         cfg.presc     <= presc_q;
         cfg.sawtooth  <= sawtooth_q;
         cfg.cnt_start <= start_q;
         cfg.cnt_end   <= end_q;
         for (int i = 0; i < N_CH; i++) begin
            cfg.comp[i] <= comp_q[i];
            cfg.op[i]   <= comp_op_e'(op_q[i]);
         end
      end
   end

   // Read-back mux, zero for REG_CMD and unmapped offsets
   always_comb begin
      rdata    = '0;
      addr_hit = 1'b1;
      case (paddr_i)
         REG_CMD: ;
         REG_CFG: begin
            rdata[PRESC_W-1:0] = presc_q;
            rdata[8]           = sawtooth_q;
         end
         REG_TH: rdata = {end_q, start_q};
         REG_COUNTER: rdata[CNT_W-1:0] = counter_i;
         REG_STATUS: begin
            rdata[0]   = running_i;
            rdata[7:4] = pwm_i;
         end
         default: begin
            if (ch_hit) begin
               rdata[15:0]  = comp_q[ch_idx];
               rdata[18:16] = op_q[ch_idx];
            end else begin
               addr_hit = 1'b0;
            end
         end
      endcase
   end

   assign prdata_o  = rd_en ? rdata : '0;
   assign pslverr_o = access & ~addr_hit;

endmodule

// ==== timer_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Prescaled 16-bit timer counter, sawtooth or centred
// Emits tick and period start pulses for the compare channels
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module timer_counter (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   timer_cfg_if.cnt                          cfg,
   output logic [adv_timer_pkg::CNT_W-1:0]   counter_o,
   output logic                              tick_o,
   output logic                              period_start_o,
   output logic                              running_o
);
   import adv_timer_pkg::*;

   cnt_state_e         state;
   logic [PRESC_W-1:0] presc_cnt;
   logic [CNT_W-1:0]   cnt_inc;
   logic [CNT_W-1:0]   cnt_dec;

   assign cnt_inc   = counter_o + 1'b1;
   assign cnt_dec   = counter_o - 1'b1;
   assign running_o = (state != ST_IDLE);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state          <= ST_IDLE;
         counter_o      <= '0;
         presc_cnt      <= '0;
         tick_o         <= 1'b0;
         period_start_o <= 1'b0;
      end else begin
         tick_o         <= 1'b0;
         period_start_o <= 1'b0;
         if (cfg.rst_p) begin
            // Reload only, run state is kept
            counter_o      <= cfg.cnt_start;
            presc_cnt      <= '0;
            period_start_o <= 1'b1;
         end else if (state != ST_IDLE) begin
            if (presc_cnt == cfg.presc) begin
               presc_cnt <= '0;
               tick_o    <= 1'b1;
               if (cfg.sawtooth) begin
                  state <= ST_UP;
                  if (counter_o >= cfg.cnt_end || counter_o < cfg.cnt_start) begin
                     counter_o      <= cfg.cnt_start;  // Wrap
                     period_start_o <= 1'b1;
                  end else begin
                     counter_o <= cnt_inc;
                  end
               end else if (state == ST_UP) begin
                  if (counter_o >= cfg.cnt_end) begin
                     state <= ST_DOWN;  // Turn at the top
                     if (counter_o > cfg.cnt_start)
                        counter_o <= cnt_dec;
                  end else begin
                     counter_o <= cnt_inc;
                  end
               end else begin
                  if (counter_o <= cfg.cnt_start) begin
                     state <= ST_UP;
                     if (counter_o < cfg.cnt_end)
                        counter_o <= cnt_inc;
                  end else begin
                     counter_o <= cnt_dec;
                     // Bottom of the triangle starts a new period
                     if (cnt_dec == cfg.cnt_start)
                        period_start_o <= 1'b1;
                  end
               end
            end else begin
               presc_cnt <= presc_cnt + 1'b1;
            end
         end
         // Run control last so stop wins over a step
         if (cfg.stop_p)
            state <= ST_IDLE;
         else if (cfg.start_p && state == ST_IDLE)
            state <= ST_UP;
      end
   end

endmodule

// ==== timer_comp_ch.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// One compare channel driving a PWM output
// CH_IDX picks its entry in the configuration arrays
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module timer_comp_ch #(
   parameter int CH_IDX = 0
) (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   timer_cfg_if.ch                           cfg,
   input  logic [adv_timer_pkg::CNT_W-1:0]   counter_i,
   input  logic                              tick_i,
   input  logic                              period_start_i,
   output logic                              pwm_o
);
   import adv_timer_pkg::*;

   logic match;

   // Only a fresh counter value can match
   assign match = tick_i && (counter_i == cfg.comp[CH_IDX]);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pwm_o <= 1'b0;
      end else if (cfg.rst_p) begin
         pwm_o <= 1'b0;
      end else if (match) begin
         case (cfg.op[CH_IDX])
            OP_SET:     pwm_o <= 1'b1;
            OP_CLEAR:   pwm_o <= 1'b0;
            OP_TOGGLE:  pwm_o <= ~pwm_o;
            OP_SET_CLR: pwm_o <= 1'b1;
            default:    pwm_o <= pwm_o;  // Unused codes hold
         endcase
      end else if (period_start_i && cfg.op[CH_IDX] == OP_SET_CLR) begin
         pwm_o <= 1'b0;
      end
   end

endmodule

// ==== adv_timer_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// APB advanced timer top, one counter with four compare channels
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module adv_timer_top (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [adv_timer_pkg::ADDR_W-1:0]  paddr_i,
   input  logic [adv_timer_pkg::DATA_W-1:0]  pwdata_i,
   output logic [adv_timer_pkg::DATA_W-1:0]  prdata_o,
   output logic                              pslverr_o,
   output logic [adv_timer_pkg::N_CH-1:0]    pwm_o
);
   import adv_timer_pkg::*;

   logic [CNT_W-1:0] counter;
   logic             tick;
   logic             period_start;
   logic             running;

   timer_cfg_if cfg_if ();

   apb_timer_regs u_regs (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .counter_i (counter),
      .running_i (running),
      .pwm_i     (pwm_o),
      .prdata_o  (prdata_o),
      .pslverr_o (pslverr_o),
      .cfg       (cfg_if.regs)
   );

   timer_counter u_cnt (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .cfg            (cfg_if.cnt),
      .counter_o      (counter),
      .tick_o         (tick),
      .period_start_o (period_start),
      .running_o      (running)
   );

   for (genvar i = 0; i < N_CH; i++) begin : g_ch
      timer_comp_ch #(.CH_IDX(i)) u_ch (
         .clk_i          (clk_i),
         .rst_n_i        (rst_n_i),
         .cfg            (cfg_if.ch),
         .counter_i      (counter),
         .tick_i         (tick),
         .period_start_i (period_start),
         .pwm_o          (pwm_o[i])
      );
   end

endmodule

// ==== adv_timer_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the timer, bound into the top level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module adv_timer_props (
   input logic                             clk_i,
   input logic                             rst_n_i,
   input logic                             psel_i,
   input logic                             penable_i,
   input logic                             pslverr_i,
   input logic [adv_timer_pkg::DATA_W-1:0] prdata_i,
   input logic                             running_i,
   input logic [adv_timer_pkg::CNT_W-1:0]  counter_i,
   input logic [adv_timer_pkg::CNT_W-1:0]  cnt_start_i,
   input logic [adv_timer_pkg::CNT_W-1:0]  cnt_end_i,
   input logic                             start_p_i,
   input logic                             stop_p_i,
   input logic                             rst_p_i
);

   // Error only in an access phase and never with read data
   a_pslverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_i |-> (psel_i && penable_i && prdata_i == '0))
      else $error("pslverr_o high outside an access phase or with nonzero read data");

   // Counter bounded by the active thresholds
   a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      running_i |-> (counter_i >= cnt_start_i && counter_i <= cnt_end_i))
      else $error("counter outside the active thresholds while running");

   a_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      start_p_i |=> !start_p_i)
      else $error("start pulse longer than one cycle");

   a_stop_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      stop_p_i |=> !stop_p_i)
      else $error("stop pulse longer than one cycle");

   a_rst_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rst_p_i |=> !rst_p_i)
      else $error("reset pulse longer than one cycle");

endmodule

bind adv_timer_top adv_timer_props u_props (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .psel_i      (psel_i),
   .penable_i   (penable_i),
   .pslverr_i   (pslverr_o),
   .prdata_i    (prdata_o),
   .running_i   (running),
   .counter_i   (counter),
   .cnt_start_i (cfg_if.cnt_start),
   .cnt_end_i   (cfg_if.cnt_end),
   .start_p_i   (cfg_if.start_p),
   .stop_p_i    (cfg_if.stop_p),
   .rst_p_i     (cfg_if.rst_p)
);

// ==== tb_adv_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the APB advanced timer
// Drives APB accesses and checks counter and PWM behaviour
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_adv_timer;
   import adv_timer_pkg::*;

   logic              clk_i = 1'b0;
   logic              rst_n_i;
   logic              psel_i;
   logic              penable_i;
   logic              pwrite_i;
   logic [ADDR_W-1:0] paddr_i;
   logic [DATA_W-1:0] pwdata_i;
   logic [DATA_W-1:0] prdata_o;
   logic              pslverr_o;
   logic [N_CH-1:0]   pwm_o;
   int                errors;
   int                checks;

   always #4 clk_i = ~clk_i;  // 8 ns period

   adv_timer_top u_adv_timer_top (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pslverr_o (pslverr_o),
      .pwm_o     (pwm_o)
   );

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
   endtask

   // Setup phase, then access phase; the write lands on the following edge
   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge clk_i);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(posedge clk_i);
      #1 penable_i = 1'b1;
      @(posedge clk_i);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      @(posedge clk_i);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(posedge clk_i);
      #1 penable_i = 1'b1;
      @(negedge clk_i);  // Mid-cycle sample of the combinational read data
      data = prdata_o;
      err  = pslverr_o;
      @(posedge clk_i);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic send_command(input int bit_idx);
      apb_write(REG_CMD, 32'h1 << bit_idx);
   endtask

   task automatic stop_and_check();
      logic [DATA_W-1:0] first;
      logic [DATA_W-1:0] second;
      logic              err;
      send_command(CMD_STOP_BIT);
      apb_read(REG_COUNTER, first, err);
      apb_read(REG_COUNTER, second, err);
      check("counter frozen after stop", second, first);
      apb_read(REG_STATUS, first, err);
      check("status running", {31'd0, first[0]}, 32'd0);
   endtask

   task automatic reset_state_reads_zero();
      logic [DATA_W-1:0] data;
      logic              err;
      apb_read(REG_COUNTER, data, err);
      check("REG_COUNTER", data, 32'd0);
      apb_read(REG_STATUS, data, err);
      check("REG_STATUS", data, 32'd0);
      check("pwm_o", {28'd0, pwm_o}, 32'd0);
   endtask

   task automatic registers_read_back();
      logic [ADDR_W-1:0] addrs [6];
      logic [DATA_W-1:0] masks [6];
      logic [DATA_W-1:0] val;
      logic [DATA_W-1:0] data;
      logic              err;
      addrs = '{REG_CFG, REG_TH, REG_CH0, REG_CH1, REG_CH2, REG_CH3};
      masks = '{32'h0000_01FF, 32'hFFFF_FFFF, 32'h0007_FFFF, 32'h0007_FFFF,
                32'h0007_FFFF, 32'h0007_FFFF};
      for (int i = 0; i < 6; i++) begin
         val = $urandom();
         apb_write(addrs[i], val);
         apb_read(addrs[i], data, err);
         check($sformatf("readback 0x%02h", addrs[i]), data, val & masks[i]);
         check("pslverr_o mapped", {31'd0, err}, 32'd0);
      end
      apb_read(REG_CMD, data, err);
      check("REG_CMD read", data, 32'd0);
      apb_read(8'h24, data, err);  // Just past REG_STATUS
      check("pslverr_o unmapped", {31'd0, err}, 32'd1);
      check("prdata_o unmapped", data, 32'd0);
   endtask

   task automatic thresholds_wait_for_update();
      logic [DATA_W-1:0] data;
      logic              err;
      apb_write(REG_TH, {16'd100, 16'd5});
      send_command(CMD_RESET_BIT);
      apb_read(REG_COUNTER, data, err);
      check("counter before update", data, 32'd0);  // Old active start
      send_command(CMD_UPDATE_BIT);
      send_command(CMD_RESET_BIT);
      apb_read(REG_COUNTER, data, err);
      check("counter after update", data, 32'd5);
   endtask

   task automatic sawtooth_count_wraps();
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] prev;
      logic              err;
      int                wraps;
      int                n;
      apb_write(REG_CFG, 32'h0000_0100);  // Presc 0, sawtooth
      apb_write(REG_TH, {16'd9, 16'd0});
      send_command(CMD_UPDATE_BIT);
      send_command(CMD_RESET_BIT);
      send_command(CMD_START_BIT);
      apb_read(REG_COUNTER, prev, err);
      wraps = 0;
      n     = 0;
      while (wraps < 2 && n < 40) begin
         apb_read(REG_COUNTER, data, err);
         if (data > 32'd9)
            report_failure($sformatf("sawtooth count %0d beyond end value 9", data));
         if (data < prev)
            wraps++;
         prev = data;
         n++;
      end
      if (wraps == 0)
         report_failure("timeout, no wrap seen in sawtooth mode");
      stop_and_check();
   endtask

   task automatic centred_count_turns();
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] prev;
      logic              err;
      int                rises;
      int                falls;
      int                n;
      apb_write(REG_CFG, 32'h0000_0000);  // Presc 0, up/down
      apb_write(REG_TH, {16'd20, 16'd0});
      send_command(CMD_UPDATE_BIT);
      send_command(CMD_RESET_BIT);
      send_command(CMD_START_BIT);
      apb_read(REG_COUNTER, prev, err);
      rises = 0;
      falls = 0;
      n     = 0;
      while ((rises == 0 || falls == 0) && n < 60) begin
         apb_read(REG_COUNTER, data, err);
         if (data > 32'd20)
            report_failure($sformatf("centred count %0d beyond end value 20", data));
         if (data > prev)
            rises++;
         else if (data < prev)
            falls++;
         prev = data;
         n++;
      end
      if (rises == 0 || falls == 0)
         report_failure("timeout, centred count did not both rise and fall");
      stop_and_check();
   endtask

   task automatic compare_actions_drive_pwm();
      logic first_lvl;
      logic seen_set;
      logic fell0;
      logic high3;
      logic seen_hi;
      logic seen_lo;
      logic toggled;
      int   n;
      apb_write(REG_CFG, 32'h0000_010F);  // Presc 15, sawtooth
      apb_write(REG_TH, {16'd9, 16'd0});
      apb_write(REG_CH0, {13'd0, OP_SET, 16'd3});
      apb_write(REG_CH1, {13'd0, OP_SET_CLR, 16'd5});
      apb_write(REG_CH2, {13'd0, OP_TOGGLE, 16'd7});
      apb_write(REG_CH3, {13'd0, OP_CLEAR, 16'd2});
      send_command(CMD_UPDATE_BIT);
      send_command(CMD_RESET_BIT);
      send_command(CMD_START_BIT);
      first_lvl = pwm_o[2];
      {seen_set, fell0, high3, seen_hi, seen_lo, toggled} = '0;
      n = 0;
      while (!(seen_set && seen_hi && seen_lo && toggled) && n < 600) begin
         @(negedge clk_i);
         if (seen_set && !pwm_o[0]) fell0 = 1'b1;
         if (pwm_o[0]) seen_set = 1'b1;
         if (pwm_o[1]) seen_hi = 1'b1;
         else if (seen_hi) seen_lo = 1'b1;  // Low again at the next period start
         if (pwm_o[2] !== first_lvl) toggled = 1'b1;
         if (pwm_o[3]) high3 = 1'b1;
         n++;
      end
      if (!seen_set) report_failure("timeout waiting for pwm_o[0] to go high");
      if (fell0) report_failure("pwm_o[0] dropped after its OP_SET match");
      if (!(seen_hi && seen_lo)) report_failure("timeout, pwm_o[1] not seen high then low");
      if (!toggled) report_failure("timeout waiting for pwm_o[2] to toggle");
      if (high3) report_failure("pwm_o[3] went high under OP_CLEAR");
      send_command(CMD_STOP_BIT);
      send_command(CMD_RESET_BIT);
      n = 0;
      while (pwm_o !== '0 && n < 20) begin
         @(negedge clk_i);
         n++;
      end
      if (pwm_o !== '0) report_failure("timeout waiting for reset command to clear pwm_o");
      check("pwm_o after reset command", {28'd0, pwm_o}, 32'd0);
   endtask

   // Watchdog in case a task never returns
   initial begin
      #500_000;
      $display("ERROR: simulation watchdog expired");
      $display("Finished with errors");
      $finish;
   end

   initial begin
      errors = 0;
      checks = 0;
      void'($urandom(32'h37852d34));
      rst_n_i   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      repeat (4) @(posedge clk_i);
      #1 rst_n_i = 1'b1;
      reset_state_reads_zero();
      registers_read_back();
      thresholds_wait_for_update();
      sawtooth_count_wraps();
      centred_count_turns();
      compare_actions_drive_pwm();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// ==== flist.f ====
adv_timer_pkg.sv
timer_cfg_if.sv
apb_timer_regs.sv
timer_counter.sv
timer_comp_ch.sv
adv_timer_top.sv
adv_timer_props.sv
tb_adv_timer.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_adv_timer
FLIST     = flist.f
LOG       = sim.log
FAIL_MSG  = Finished with errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
